// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_rvseed_core
FLIST     ?= rvseed_core.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TEST OK

.PHONY: sim clean

# build, run, and judge the run by the pass line in its output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/rvseed_core.sv ====
`include "rvseed_params.svh"

module rvseed_core (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         ena,
   input  logic [31:0]                  inst,
   output logic [`RVSEED_CPU_WIDTH-1:0] pc,
   output rvseed_pkg::wb_t              wb,
   output logic                         halted
);

   rvseed_pkg::ctrl_t            ctrl;
   rvseed_pkg::exec_t            ex;
   rvseed_pkg::wb_t              wb_raw;
   logic [`RVSEED_CPU_WIDTH-1:0] rs1_data;
   logic [`RVSEED_CPU_WIDTH-1:0] rs2_data;
   logic [`RVSEED_CPU_WIDTH-1:0] next_pc;
   logic                         commit;

   assign commit = ena && !halted;   // instruction retires this edge

   rvseed_decode i_rvseed_decode (
      .inst (inst),
      .ctrl (ctrl)
   );

   rvseed_regfile i_rvseed_regfile (
      .clk      (clk),
      .rst_n    (rst_n),
      .rs1      (ctrl.rs1),
      .rs2      (ctrl.rs2),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data),
      .wb       (wb)
   );

   rvseed_execute i_rvseed_execute (
      .ctrl     (ctrl),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data),
      .ex       (ex)
   );

   rvseed_muxpc i_rvseed_muxpc (
      .ctrl    (ctrl),
      .ex      (ex),
      .pc      (pc),
      .next_pc (next_pc),
      .wb      (wb_raw)
   );

   always_comb begin
      wb    = wb_raw;
      wb.we = wb_raw.we && commit;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc     <= `RVSEED_RESET_PC;
         halted <= 1'b0;
      end else if (commit) begin
         pc <= next_pc;
         if (ctrl.kind == rvseed_pkg::KIND_EBREAK) begin
            halted <= 1'b1;   // sticky until reset
         end
      end
   end

endmodule

// ==== design/rvseed_decode.sv ====
`include "rvseed_params.svh"

module rvseed_decode (
   input  logic [31:0]         inst,
   output rvseed_pkg::ctrl_t   ctrl
);

   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;
   localparam logic [6:0] OPC_JALR   = 7'b1100111;
   localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

   localparam logic [31:0] INST_EBREAK = 32'h0010_0073;

   logic [6:0]                   opcode;
   logic [2:0]                   funct3;
   logic [6:0]                   funct7;
   logic [`RVSEED_CPU_WIDTH-1:0] imm_i;
   logic [`RVSEED_CPU_WIDTH-1:0] imm_u;
   logic [`RVSEED_CPU_WIDTH-1:0] imm_b;
   logic [`RVSEED_CPU_WIDTH-1:0] imm_j;

   assign opcode = inst[6:0];
   assign funct3 = inst[14:12];
   assign funct7 = inst[31:25];

   assign imm_i = {{(`RVSEED_CPU_WIDTH-12){inst[31]}}, inst[31:20]};
   assign imm_u = {{(`RVSEED_CPU_WIDTH-32){inst[31]}}, inst[31:12], 12'b0};
   assign imm_b = {{(`RVSEED_CPU_WIDTH-13){inst[31]}}, inst[31], inst[7],
                   inst[30:25], inst[11:8], 1'b0};
   assign imm_j = {{(`RVSEED_CPU_WIDTH-21){inst[31]}}, inst[31], inst[19:12],
                   inst[20], inst[30:21], 1'b0};

   always_comb begin
      ctrl        = '0;
      ctrl.kind   = rvseed_pkg::KIND_ILLEGAL;
      ctrl.alu_op = rvseed_pkg::ALU_ADD;
      ctrl.rd     = inst[11:7];
      ctrl.rs1    = inst[19:15];
      ctrl.rs2    = inst[24:20];
      ctrl.imm    = imm_i;

      case (opcode)
         OPC_OP_IMM: begin
            if (funct3 == 3'b000) begin   // addi only
               ctrl.kind = rvseed_pkg::KIND_ALUI;
            end
         end
         OPC_LUI: begin
            ctrl.kind = rvseed_pkg::KIND_LUI;
            ctrl.imm  = imm_u;
         end
         OPC_OP: begin
            ctrl.kind = rvseed_pkg::KIND_ALU;
            case ({funct7, funct3})
               10'b0000000_000: ctrl.alu_op = rvseed_pkg::ALU_ADD;
               10'b0100000_000: ctrl.alu_op = rvseed_pkg::ALU_SUB;
               10'b0000000_111: ctrl.alu_op = rvseed_pkg::ALU_AND;
               10'b0000000_110: ctrl.alu_op = rvseed_pkg::ALU_OR;
               10'b0000000_100: ctrl.alu_op = rvseed_pkg::ALU_XOR;
               10'b0000000_010: ctrl.alu_op = rvseed_pkg::ALU_SLT;
               10'b0000000_011: ctrl.alu_op = rvseed_pkg::ALU_SLTU;
               default:         ctrl.kind   = rvseed_pkg::KIND_ILLEGAL;
            endcase
         end
         OPC_BRANCH: begin
            ctrl.kind = rvseed_pkg::KIND_BRANCH;
            ctrl.imm  = imm_b;
            case (funct3)
               3'b000:  ctrl.alu_op = rvseed_pkg::ALU_BEQ;
               3'b001:  ctrl.alu_op = rvseed_pkg::ALU_BNE;
               3'b100:  ctrl.alu_op = rvseed_pkg::ALU_BLT;
               3'b101:  ctrl.alu_op = rvseed_pkg::ALU_BGE;
               3'b110:  ctrl.alu_op = rvseed_pkg::ALU_BLTU;
               3'b111:  ctrl.alu_op = rvseed_pkg::ALU_BGEU;
               default: ctrl.kind   = rvseed_pkg::KIND_ILLEGAL;
            endcase
         end
         OPC_JAL: begin
            ctrl.kind = rvseed_pkg::KIND_JAL;
            ctrl.imm  = imm_j;
         end
         OPC_JALR: begin
            if (funct3 == 3'b000) begin
               ctrl.kind = rvseed_pkg::KIND_JALR;
            end
         end
         OPC_SYSTEM: begin
            if (inst == INST_EBREAK) begin   // ecall and csr ops fall through
               ctrl.kind = rvseed_pkg::KIND_EBREAK;
            end
         end
         default: begin
            ctrl.kind = rvseed_pkg::KIND_ILLEGAL;
         end
      endcase

      case (ctrl.kind)
         rvseed_pkg::KIND_ALU,
         rvseed_pkg::KIND_ALUI,
         rvseed_pkg::KIND_LUI,
         rvseed_pkg::KIND_JAL,
         rvseed_pkg::KIND_JALR: ctrl.reg_write = (ctrl.rd != 5'd0);   // x0 never written
         default:               ctrl.reg_write = 1'b0;
      endcase
   end

endmodule

// ==== design/rvseed_execute.sv ====
`include "rvseed_params.svh"

module rvseed_execute (
   input  rvseed_pkg::ctrl_t            ctrl,
   input  logic [`RVSEED_CPU_WIDTH-1:0] rs1_data,
   input  logic [`RVSEED_CPU_WIDTH-1:0] rs2_data,
   output rvseed_pkg::exec_t            ex
);

   logic [`RVSEED_CPU_WIDTH-1:0] op_a;
   logic [`RVSEED_CPU_WIDTH-1:0] op_b;
   logic [`RVSEED_CPU_WIDTH-1:0] sum;
   logic [`RVSEED_CPU_WIDTH-1:0] diff;
   logic [`RVSEED_CPU_WIDTH-1:0] res;
   logic                         eq;
   logic                         lt_s;
   logic                         lt_u;
   logic                         cond;

   assign op_a = rs1_data;
   assign op_b = (ctrl.kind == rvseed_pkg::KIND_ALUI ||
                  ctrl.kind == rvseed_pkg::KIND_JALR) ? ctrl.imm : rs2_data;

   assign sum  = op_a + op_b;
   assign diff = op_a - op_b;
   assign eq   = (op_a == op_b);
   assign lt_s = ($signed(op_a) < $signed(op_b));
   assign lt_u = (op_a < op_b);

   always_comb begin
      res  = sum;
      cond = 1'b0;
      case (ctrl.alu_op)
         rvseed_pkg::ALU_ADD:  res = sum;
         rvseed_pkg::ALU_SUB:  res = diff;
         rvseed_pkg::ALU_AND:  res = op_a & op_b;
         rvseed_pkg::ALU_OR:   res = op_a | op_b;
         rvseed_pkg::ALU_XOR:  res = op_a ^ op_b;
         rvseed_pkg::ALU_SLT:  res = {{(`RVSEED_CPU_WIDTH-1){1'b0}}, lt_s};
         rvseed_pkg::ALU_SLTU: res = {{(`RVSEED_CPU_WIDTH-1){1'b0}}, lt_u};
         rvseed_pkg::ALU_BEQ: begin
            res  = diff;
            cond = eq;
         end
         rvseed_pkg::ALU_BNE: begin
            res  = diff;
            cond = !eq;
         end
         rvseed_pkg::ALU_BLT: begin
            res  = diff;
            cond = lt_s;
         end
         rvseed_pkg::ALU_BGE: begin
            res  = diff;
            cond = !lt_s;
         end
         rvseed_pkg::ALU_BLTU: begin
            res  = diff;
            cond = lt_u;
         end
         rvseed_pkg::ALU_BGEU: begin
            res  = diff;
            cond = !lt_u;
         end
         default: begin
            res  = sum;
            cond = 1'b0;
         end
      endcase
   end

   always_comb begin
      ex.alu_res  = (ctrl.kind == rvseed_pkg::KIND_LUI) ? ctrl.imm : res;
      ex.taken    = cond && (ctrl.kind == rvseed_pkg::KIND_BRANCH);   // only branches redirect here
      ex.rs1_data = rs1_data;
   end

endmodule

// ==== design/rvseed_muxpc.sv ====
`include "rvseed_params.svh"

module rvseed_muxpc (
   input  rvseed_pkg::ctrl_t            ctrl,
   input  rvseed_pkg::exec_t            ex,
   input  logic [`RVSEED_CPU_WIDTH-1:0] pc,
   output logic [`RVSEED_CPU_WIDTH-1:0] next_pc,
   output rvseed_pkg::wb_t              wb
);

   logic [`RVSEED_CPU_WIDTH-1:0] pc_plus4;
   logic [`RVSEED_CPU_WIDTH-1:0] pc_rel;
   logic [`RVSEED_CPU_WIDTH-1:0] jalr_tgt;
   logic                         is_jal;
   logic                         is_jalr;

   assign pc_plus4 = pc + `RVSEED_CPU_WIDTH'd4;
   assign pc_rel   = pc + ctrl.imm;
   assign jalr_tgt = (ex.rs1_data + ctrl.imm) & ~`RVSEED_CPU_WIDTH'd1;   // lsb dropped

   assign is_jal  = (ctrl.kind == rvseed_pkg::KIND_JAL);
   assign is_jalr = (ctrl.kind == rvseed_pkg::KIND_JALR);

   always_comb begin
      if (ex.taken || is_jal) begin
         next_pc = pc_rel;
      end else if (is_jalr) begin
         next_pc = jalr_tgt;
      end else if (ctrl.kind == rvseed_pkg::KIND_EBREAK) begin
         next_pc = `RVSEED_TRAP_PC;
      end else begin
         next_pc = pc_plus4;   // also not-taken and illegal
      end
   end

   always_comb begin
      wb.rd   = ctrl.rd;
      wb.data = (is_jal || is_jalr) ? pc_plus4 : ex.alu_res;   // link address
      wb.we   = ctrl.reg_write;
   end

endmodule

// ==== design/rvseed_params.svh ====
`ifndef RVSEED_PARAMS_SVH
`define RVSEED_PARAMS_SVH

// data and address width of the core
`define RVSEED_CPU_WIDTH 64

// architectural registers, x0 included
`define RVSEED_REG_DEPTH 32

// first fetch address after reset
`define RVSEED_RESET_PC 64'h0000_0000_8000_0000

// ebreak lands here and the core stops
`define RVSEED_TRAP_PC 64'h0000_0000_8000_0000

`endif

// ==== design/rvseed_pkg.sv ====
`include "rvseed_params.svh"

package rvseed_pkg;

   typedef enum logic [2:0] {
      KIND_ALU,      // register-register
      KIND_ALUI,     // register-immediate
      KIND_LUI,
      KIND_BRANCH,
      KIND_JAL,
      KIND_JALR,
      KIND_EBREAK,
      KIND_ILLEGAL   // stepped over as pc+4
   } inst_kind_e;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_SLTU,
      ALU_BEQ,
      ALU_BNE,
      ALU_BLT,
      ALU_BGE,
      ALU_BLTU,
      ALU_BGEU
   } alu_op_e;

   typedef struct packed {
      inst_kind_e                   kind;
      alu_op_e                      alu_op;
      logic [4:0]                   rd;
      logic [4:0]                   rs1;
      logic [4:0]                   rs2;
      logic [`RVSEED_CPU_WIDTH-1:0] imm;       // sign extended
      logic                         reg_write;
   } ctrl_t;

   typedef struct packed {
      logic [`RVSEED_CPU_WIDTH-1:0] alu_res;
      logic                         taken;     // branch condition true
      logic [`RVSEED_CPU_WIDTH-1:0] rs1_data;  // jalr base
   } exec_t;

   typedef struct packed {
      logic [4:0]                   rd;
      logic [`RVSEED_CPU_WIDTH-1:0] data;
      logic                         we;
   } wb_t;

endpackage

// ==== design/rvseed_regfile.sv ====
`include "rvseed_params.svh"

module rvseed_regfile (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic [4:0]                   rs1,
   input  logic [4:0]                   rs2,
   output logic [`RVSEED_CPU_WIDTH-1:0] rs1_data,
   output logic [`RVSEED_CPU_WIDTH-1:0] rs2_data,
   input  rvseed_pkg::wb_t              wb
);

   logic [`RVSEED_CPU_WIDTH-1:0] regs [0:`RVSEED_REG_DEPTH-1];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `RVSEED_REG_DEPTH; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.we && (wb.rd != 5'd0)) begin
         regs[wb.rd] <= wb.data;
      end
   end

   // x0 is hardwired
   assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
   assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// ==== rvseed_core.f ====
+incdir+design
design/rvseed_pkg.sv
design/rvseed_decode.sv
design/rvseed_regfile.sv
design/rvseed_execute.sv
design/rvseed_muxpc.sv
design/rvseed_core.sv
verif/tb_rvseed_core.sv

// ==== verif/tb_rvseed_core.sv ====
`include "rvseed_params.svh"

module tb_rvseed_core;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int N_ALU       = 2000;
   localparam int N_BR        = 300;
   localparam int N_JMP       = 200;
   localparam int N_IDLE_RUNS = 20;
   localparam int N_POST      = 20;
   localparam int RST_CYCLES  = 5;
   localparam int MAX_CYCLES  = RST_CYCLES + N_ALU + 3 * N_BR + 2 * N_JMP
                                + 9 * N_IDLE_RUNS + N_POST + 2 + 100;

   // opcodes 0 to 8 form the plain alu group
   localparam int OP_ADD    = 0;
   localparam int OP_SUB    = 1;
   localparam int OP_AND    = 2;
   localparam int OP_OR     = 3;
   localparam int OP_XOR    = 4;
   localparam int OP_SLT    = 5;
   localparam int OP_SLTU   = 6;
   localparam int OP_ADDI   = 7;
   localparam int OP_LUI    = 8;
   localparam int OP_BEQ    = 9;
   localparam int OP_BNE    = 10;
   localparam int OP_BLT    = 11;
   localparam int OP_BGE    = 12;
   localparam int OP_BLTU   = 13;
   localparam int OP_BGEU   = 14;
   localparam int OP_JAL    = 15;
   localparam int OP_JALR   = 16;
   localparam int OP_EBREAK = 17;

   logic                         clk;
   logic                         rst_n;
   logic                         ena;
   logic [31:0]                  inst;
   logic [`RVSEED_CPU_WIDTH-1:0] pc;
   rvseed_pkg::wb_t              wb;
   logic                         halted;

   logic [63:0] m_regs [0:31];   // reference register file
   logic [63:0] m_pc;
   logic        m_halted;
   int          cycles;

   rvseed_core i_rvseed_core (
      .clk    (clk),
      .rst_n  (rst_n),
      .ena    (ena),
      .inst   (inst),
      .pc     (pc),
      .wb     (wb),
      .halted (halted)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic report_failure(input string line);
      $display("%s", line);
      $display("TEST FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_pc(input string name, input logic [63:0] exp, input logic [63:0] act);
      if (act !== exp) begin
         report_failure($sformatf("FAIL %s pc: expected %h actual %h", name, exp, act));
      end
   endtask

   task automatic check_wb(input string name, input rvseed_pkg::wb_t exp,
                           input rvseed_pkg::wb_t act);
      string exp_s;
      string act_s;
      if (act.we !== exp.we || (exp.we && (act.rd !== exp.rd || act.data !== exp.data))) begin
         exp_s = $sformatf("rd=%0d data=%h we=%b", exp.rd, exp.data, exp.we);
         act_s = $sformatf("rd=%0d data=%h we=%b", act.rd, act.data, act.we);
         report_failure($sformatf("FAIL %s wb: expected %s actual %s", name, exp_s, act_s));
      end
   endtask

   task automatic check_halted(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         report_failure($sformatf("FAIL %s halted: expected %b actual %b", name, exp, act));
      end
   endtask

   function automatic logic [2:0] branch_f3(input int op);
      case (op)
         OP_BEQ:  return 3'b000;
         OP_BNE:  return 3'b001;
         OP_BLT:  return 3'b100;
         OP_BGE:  return 3'b101;
         OP_BLTU: return 3'b110;
         default: return 3'b111;
      endcase
   endfunction

   function automatic logic [31:0] encode_instr(input int op, input logic [4:0] rd,
                                                input logic [4:0] rs1, input logic [4:0] rs2,
                                                input logic [63:0] imm);
      case (op)
         OP_ADD:    return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
         OP_SUB:    return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
         OP_AND:    return {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
         OP_OR:     return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
         OP_XOR:    return {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
         OP_SLT:    return {7'b0000000, rs2, rs1, 3'b010, rd, 7'b0110011};
         OP_SLTU:   return {7'b0000000, rs2, rs1, 3'b011, rd, 7'b0110011};
         OP_ADDI:   return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
         OP_LUI:    return {imm[31:12], rd, 7'b0110111};
         OP_JAL:    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
         OP_JALR:   return {imm[11:0], rs1, 3'b000, rd, 7'b1100111};
         OP_EBREAK: return 32'h0010_0073;
         default:   return {imm[12], imm[10:5], rs2, rs1, branch_f3(op), imm[4:1], imm[11],
                            7'b1100011};
      endcase
   endfunction

   function automatic logic [63:0] make_imm(input int op);
      logic [31:0] r;
      int          o;
      r = $urandom;
      case (op)
         OP_LUI: return {{32{r[31]}}, r[31:12], 12'h000};
         OP_JAL: begin
            o = (int'(r[9:0]) - 512) * 4;
            return 64'(o);
         end
         OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: begin
            o = (int'(r[6:0]) - 64) * 4;   // short hop either way
            return 64'(o);
         end
         default: return {{52{r[11]}}, r[11:0]};
      endcase
   endfunction

   function automatic logic branch_taken(input int op, input logic [63:0] a,
                                         input logic [63:0] b);
      case (op)
         OP_BEQ:  return a == b;
         OP_BNE:  return a != b;
         OP_BLT:  return $signed(a) < $signed(b);
         OP_BGE:  return $signed(a) >= $signed(b);
         OP_BLTU: return a < b;
         default: return a >= b;
      endcase
   endfunction

   task automatic model_step(input int op, input logic [4:0] rd, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic [63:0] imm,
                             output logic [63:0] data, output logic writes,
                             output logic [63:0] nxt);
      logic [63:0] a;
      logic [63:0] b;
      a      = m_regs[rs1];
      b      = m_regs[rs2];
      data   = '0;
      writes = (rd != 5'd0);
      nxt    = m_pc + 64'd4;
      case (op)
         OP_ADD:  data = a + b;
         OP_SUB:  data = a - b;
         OP_AND:  data = a & b;
         OP_OR:   data = a | b;
         OP_XOR:  data = a ^ b;
         OP_SLT:  data = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
         OP_SLTU: data = (a < b) ? 64'd1 : 64'd0;
         OP_ADDI: data = a + imm;
         OP_LUI:  data = imm;
         OP_JAL: begin
            data = m_pc + 64'd4;
            nxt  = m_pc + imm;
         end
         OP_JALR: begin
            data = m_pc + 64'd4;
            nxt  = (a + imm) & ~64'd1;
         end
         OP_EBREAK: begin
            writes = 1'b0;
            nxt    = `RVSEED_TRAP_PC;
         end
         default: begin   // conditional branches
            writes = 1'b0;
            if (branch_taken(op, a, b)) begin
               nxt = m_pc + imm;
            end
         end
      endcase
   endtask

   // drive one cycle, check the same-cycle response, then retire into the model
   task automatic run_instr(input string name, input int op, input logic [4:0] rd,
                            input logic [4:0] rs1, input logic [4:0] rs2,
                            input logic [63:0] imm, input logic ena_v);
      rvseed_pkg::wb_t exp_wb;
      logic [63:0]     data;
      logic [63:0]     nxt;
      logic            writes;
      logic            commit;
      @(posedge clk);
      ena  <= ena_v;
      inst <= encode_instr(op, rd, rs1, rs2, imm);
      @(negedge clk);
      commit = ena_v && !m_halted;
      model_step(op, rd, rs1, rs2, imm, data, writes, nxt);
      exp_wb.rd   = rd;
      exp_wb.data = data;
      exp_wb.we   = writes && commit;
      check_pc(name, m_pc, pc);
      check_halted(name, m_halted, halted);
      check_wb(name, exp_wb, wb);
      if (commit) begin
         if (exp_wb.we) begin
            m_regs[rd] = data;
         end
         m_pc = nxt;
         if (op == OP_EBREAK) begin
            m_halted = 1'b1;
         end
      end
   endtask

   task automatic run_random(input string name, input int lo, input int hi, input logic ena_v);
      int op;
      op = int'($urandom_range(hi, lo));
      run_instr(name, op, 5'($urandom_range(31, 0)), 5'($urandom_range(31, 0)),
                5'($urandom_range(31, 0)), make_imm(op), ena_v);
   endtask

   initial begin
      cycles = 0;
      while (cycles < MAX_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      report_failure($sformatf("run did not finish within %0d cycles", MAX_CYCLES));
   end

   initial begin
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [4:0]  tmp;
      logic [31:0] r;
      logic [63:0] imm;
      int          op;
      int          pat;
      int          n_idle;
      void'($urandom(32'ha6a4a66c));
      rst_n    = 1'b0;
      ena      = 1'b0;
      inst     = 32'h0000_0013;
      m_pc     = `RVSEED_RESET_PC;
      m_halted = 1'b0;
      for (int i = 0; i < 32; i++) begin
         m_regs[i] = '0;
      end
      repeat (RST_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_pc("reset", `RVSEED_RESET_PC, pc);
      check_halted("reset", 1'b0, halted);
      check_wb("reset", '0, wb);

      for (int i = 0; i < N_ALU; i++) begin
         run_random("alu", OP_ADD, OP_LUI, 1'b1);
      end

      for (int i = 0; i < N_BR; i++) begin
         rs1 = 5'($urandom_range(31, 1));
         rs2 = 5'($urandom_range(31, 1));
         r   = $urandom;
         pat = int'($urandom_range(3, 0));
         case (pat)
            0: begin   // equal pair
               imm = make_imm(OP_ADDI);
               run_instr("branch", OP_ADDI, rs1, 5'd0, 5'd0, imm, 1'b1);
               run_instr("branch", OP_ADDI, rs2, 5'd0, 5'd0, imm, 1'b1);
            end
            1: begin   // negative against positive
               run_instr("branch", OP_ADDI, rs1, 5'd0, 5'd0,
                         {53'h1f_ffff_ffff_ffff, r[10:0]}, 1'b1);
               run_instr("branch", OP_ADDI, rs2, 5'd0, 5'd0, {53'h0, r[21:11]}, 1'b1);
            end
            2: begin   // msb set, small in unsigned compare
               run_instr("branch", OP_LUI, rs1, 5'd0, 5'd0,
                         {32'hffff_ffff, 1'b1, r[30:12], 12'h000}, 1'b1);
               run_instr("branch", OP_ADDI, rs2, 5'd0, 5'd0, {53'h0, r[10:0]}, 1'b1);
            end
            default: begin
            end
         endcase
         if (r[31]) begin
            tmp = rs1;
            rs1 = rs2;
            rs2 = tmp;
         end
         op = int'($urandom_range(OP_BGEU, OP_BEQ));
         run_instr("branch", op, 5'd0, rs1, rs2, make_imm(op), 1'b1);
      end

      for (int i = 0; i < N_JMP; i++) begin
         rs1 = 5'($urandom_range(31, 1));
         if ($urandom_range(1, 0) == 0) begin
            run_instr("jump", OP_JAL, 5'($urandom_range(31, 0)), 5'd0, 5'd0,
                      make_imm(OP_JAL), 1'b1);
         end else begin
            run_instr("jump", OP_ADDI, rs1, 5'd0, 5'd0, make_imm(OP_ADDI), 1'b1);
            run_instr("jump", OP_JALR, 5'($urandom_range(31, 0)), rs1, 5'd0,
                      make_imm(OP_JALR), 1'b1);
         end
      end

      for (int i = 0; i < N_IDLE_RUNS; i++) begin
         n_idle = int'($urandom_range(8, 1));
         repeat (n_idle) run_random("idle", OP_ADD, OP_JALR, 1'b0);
         run_random("idle", OP_ADD, OP_LUI, 1'b1);
      end

      run_instr("halt", OP_EBREAK, 5'd0, 5'd0, 5'd0, '0, 1'b1);
      for (int i = 0; i < N_POST; i++) begin
         run_random("halt", OP_ADD, OP_JALR, 1'b1);
      end
      @(posedge clk);
      @(negedge clk);
      check_pc("halt", `RVSEED_TRAP_PC, pc);
      check_halted("halt", 1'b1, halted);
      $display("TEST OK");
      $finish;
   end

endmodule
